//--- source/sched_pkg.sv
`default_nettype none

package sched_pkg;

  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;
  localparam int PORT_COUNT = 2;
  localparam int DATA_WIDTH = 64;

  // Slot numbers start at 1, so one extra bit holds a full count
  localparam int SLOT_WIDTH     = $clog2(SLOT_COUNT + 1);
  localparam int SLOT_PTR_WIDTH = $clog2(SLOT_COUNT);
  localparam int CORE_ID_WIDTH  = $clog2(CORE_COUNT);
  localparam int PORT_ID_WIDTH  = $clog2(PORT_COUNT);

  typedef logic [CORE_ID_WIDTH-1:0]  core_id_t;
  typedef logic [SLOT_WIDTH-1:0]     slot_t;
  typedef logic [SLOT_PTR_WIDTH-1:0] slot_ptr_t;
  typedef logic [PORT_ID_WIDTH-1:0]  port_id_t;
  typedef logic [3:0]                msg_type_t;

  localparam msg_type_t MSG_SLOT_RETURN = 4'd0;
  localparam msg_type_t MSG_SLOT_INIT   = 4'd3;

  typedef struct packed {
    msg_type_t msg_type;
    core_id_t  src_core;
    slot_t     slot;
  } ctrl_msg_t;

  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } dest_tag_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } rx_beat_t;

  typedef struct packed {
    rx_beat_t  beat;
    dest_tag_t dest;
    port_id_t  port;
  } tagged_beat_t;

endpackage

`default_nettype wire

//--- source/ctrl_slot_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_slot_decoder (
  input  wire                               clk,
  input  wire                               rst_r,
  input  wire sched_pkg::ctrl_msg_t         ctrl_msg,
  input  wire                               ctrl_valid,
  output logic [sched_pkg::CORE_COUNT-1:0]  init_strobe,
  output logic [sched_pkg::CORE_COUNT-1:0]  return_strobe,
  output sched_pkg::slot_t                  slot_value
);

  import sched_pkg::*;

  logic                  is_init;
  logic                  is_return;
  logic [CORE_COUNT-1:0] core_onehot;

  assign is_init     = ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_INIT);
  assign is_return   = ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_RETURN);
  assign core_onehot = CORE_COUNT'(1) << ctrl_msg.src_core;

  // Slot field rides along with the strobes
  always_ff @(posedge clk) begin
    slot_value <= ctrl_msg.slot;
  end

  // Other message types fall through with no strobe
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_strobe   <= '0;
      return_strobe <= '0;
    end else begin
      init_strobe   <= is_init ? core_onehot : '0;
      return_strobe <= is_return ? core_onehot : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/slot_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module slot_keeper (
  input  wire                    clk,
  input  wire                    rst_r,
  input  wire                    init,
  input  wire                    push,
  input  wire sched_pkg::slot_t  slot_in,
  input  wire                    pop,
  output sched_pkg::slot_t       head,
  output logic                   head_valid,
  output sched_pkg::slot_t       count,
  output logic                   enq_err
);

  import sched_pkg::*;

  slot_t     mem [SLOT_COUNT];
  slot_ptr_t rd_ptr;
  slot_ptr_t wr_ptr;
  slot_t     init_count;
  logic      full;
  logic      pop_ok;
  logic      push_ok;

  assign full       = (count == slot_t'(SLOT_COUNT));
  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign pop_ok     = pop && head_valid;

  // A pop in the same cycle frees room for the returned slot
  assign enq_err = push && full && !pop_ok;
  assign push_ok = push && !enq_err;

  assign init_count = (slot_in > SLOT_COUNT) ? slot_t'(SLOT_COUNT) : slot_in;

  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (push_ok) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init) begin
      // Tail wraps to zero when the list is loaded full
      rd_ptr <= '0;
      wr_ptr <= slot_ptr_t'(init_count);
      count  <= init_count;
    end else begin
      if (pop_ok) begin
        rd_ptr <= rd_ptr + slot_ptr_t'(1);
      end
      if (push_ok) begin
        wr_ptr <= wr_ptr + slot_ptr_t'(1);
      end
      count <= count + slot_t'(push_ok) - slot_t'(pop_ok);
    end
  end

endmodule

`default_nettype wire

//--- source/core_selector.sv
`timescale 1ns/1ps
`default_nettype none

module core_selector (
  input  wire sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0] counts,
  input  wire [sched_pkg::CORE_COUNT-1:0]                   core_enable,
  output sched_pkg::core_id_t                               sel_core,
  output logic                                              sel_valid
);

  import sched_pkg::*;

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    slot_t best_count;
    best_count = '0;
    sel_core   = '0;
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (core_enable[i] && (counts[i] > best_count)) begin
        best_count = counts[i];
        sel_core   = core_id_t'(i);
      end
    end
    // Zero best means no enabled core has a free slot
    sel_valid = (best_count != '0);
  end

endmodule

`default_nettype wire

//--- source/port_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module port_dispatch (
  input  wire                                                   clk,
  input  wire                                                   rst_r,
  input  wire sched_pkg::rx_beat_t [sched_pkg::PORT_COUNT-1:0]  rx_beat,
  input  wire [sched_pkg::PORT_COUNT-1:0]                       rx_valid,
  output logic [sched_pkg::PORT_COUNT-1:0]                      rx_ready,
  output sched_pkg::tagged_beat_t [sched_pkg::PORT_COUNT-1:0]   out_beat,
  output logic [sched_pkg::PORT_COUNT-1:0]                      out_valid,
  input  wire [sched_pkg::PORT_COUNT-1:0]                       out_ready,
  input  wire sched_pkg::core_id_t                              sel_core,
  input  wire                                                   sel_valid,
  input  wire sched_pkg::slot_t                                 head_slot,
  output logic                                                  desc_pop
);

  import sched_pkg::*;

  typedef enum logic [1:0] {
    ST_STALL = 2'b00,  // No descriptor, hold the port
    ST_FIRST = 2'b01,  // Descriptor ready for the next packet
    ST_WAIT  = 2'b10,  // Packet flowing, next descriptor not yet fetched
    ST_MID   = 2'b11   // Packet flowing, next descriptor in hand
  } port_state_t;

  logic [PORT_COUNT-1:0] desc_req;
  logic [PORT_COUNT-1:0] xfer;
  logic [PORT_COUNT-1:0] pop_hit;
  port_id_t              grant_idx;
  port_id_t              last_grant;
  logic                  grant_valid;

  // Round-robin search starting after the last granted port
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < PORT_COUNT; k++) begin
      idx = (int'(last_grant) + 1 + k) % PORT_COUNT;
      if (!grant_valid && desc_req[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = port_id_t'(idx);
      end
    end
  end

  assign desc_pop = grant_valid && sel_valid;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_grant <= port_id_t'(PORT_COUNT - 1);
    end else if (desc_pop) begin
      last_grant <= grant_idx;
    end
  end

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    port_state_t state;
    dest_tag_t   next_dest;
    dest_tag_t   cur_dest;
    dest_tag_t   tag;
    logic        active;
    logic        last_xfer;

    assign active      = (state != ST_STALL);
    assign rx_ready[p]  = out_ready[p] && active;
    assign out_valid[p] = rx_valid[p] && active;
    assign xfer[p]      = rx_valid[p] && rx_ready[p];
    assign last_xfer    = xfer[p] && rx_beat[p].last;
    assign pop_hit[p]   = desc_pop && (grant_idx == port_id_t'(p));

    // Fetch ahead as soon as the buffered descriptor gets used
    assign desc_req[p] = (state == ST_STALL) || (state == ST_WAIT) ||
                         ((state == ST_FIRST) && xfer[p]);

    // First beat still uses the buffered descriptor
    assign tag = (state == ST_FIRST) ? next_dest : cur_dest;
    assign out_beat[p] = '{beat: rx_beat[p], dest: tag, port: port_id_t'(p)};

    always_ff @(posedge clk) begin
      if (rst_r) begin
        state <= ST_STALL;
      end else begin
        case (state)
          ST_STALL: begin
            if (pop_hit[p]) begin
              state <= ST_FIRST;
            end
          end
          ST_FIRST: begin
            if (xfer[p] && pop_hit[p]) begin
              state <= last_xfer ? ST_FIRST : ST_MID;
            end else if (xfer[p]) begin
              state <= last_xfer ? ST_STALL : ST_WAIT;
            end
          end
          ST_WAIT: begin
            if (pop_hit[p]) begin
              state <= last_xfer ? ST_FIRST : ST_MID;
            end else if (last_xfer) begin
              state <= ST_STALL;
            end
          end
          ST_MID: begin
            if (last_xfer) begin
              state <= ST_FIRST;
            end
          end
          default: state <= ST_STALL;
        endcase
      end
    end

    always_ff @(posedge clk) begin
      if (pop_hit[p]) begin
        next_dest <= '{core: sel_core, slot: head_slot};
      end
      if ((state == ST_FIRST) && xfer[p]) begin
        cur_dest <= next_dest;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/packet_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module packet_scheduler (
  input  wire                                                   clk,
  input  wire                                                   rst_r,
  input  wire sched_pkg::ctrl_msg_t                             ctrl_msg,
  input  wire                                                   ctrl_valid,
  input  wire [sched_pkg::CORE_COUNT-1:0]                       core_enable,
  input  wire sched_pkg::rx_beat_t [sched_pkg::PORT_COUNT-1:0]  rx_beat,
  input  wire [sched_pkg::PORT_COUNT-1:0]                       rx_valid,
  output logic [sched_pkg::PORT_COUNT-1:0]                      rx_ready,
  output sched_pkg::tagged_beat_t [sched_pkg::PORT_COUNT-1:0]   out_beat,
  output logic [sched_pkg::PORT_COUNT-1:0]                      out_valid,
  input  wire [sched_pkg::PORT_COUNT-1:0]                       out_ready,
  output logic                                                  slot_err
);

  import sched_pkg::*;

  logic [CORE_COUNT-1:0]    init_strobe;
  logic [CORE_COUNT-1:0]    return_strobe;
  slot_t                    slot_value;
  slot_t [CORE_COUNT-1:0]   heads;
  logic [CORE_COUNT-1:0]    head_valid;
  slot_t [CORE_COUNT-1:0]   counts;
  logic [CORE_COUNT-1:0]    enq_err;
  logic [CORE_COUNT-1:0]    keeper_pop;
  core_id_t                 sel_core;
  logic                     sel_valid;
  slot_t                    head_slot;
  logic                     desc_pop;

  ctrl_slot_decoder ctrl_slot_decoder_inst (
    .clk           (clk),
    .rst_r         (rst_r),
    .ctrl_msg      (ctrl_msg),
    .ctrl_valid    (ctrl_valid),
    .init_strobe   (init_strobe),
    .return_strobe (return_strobe),
    .slot_value    (slot_value)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_keeper
    // Pop only the list the selector pointed at
    assign keeper_pop[c] = desc_pop && head_valid[c] && (sel_core == core_id_t'(c));

    slot_keeper slot_keeper_inst (
      .clk        (clk),
      .rst_r      (rst_r),
      .init       (init_strobe[c]),
      .push       (return_strobe[c]),
      .slot_in    (slot_value),
      .pop        (keeper_pop[c]),
      .head       (heads[c]),
      .head_valid (head_valid[c]),
      .count      (counts[c]),
      .enq_err    (enq_err[c])
    );
  end

  core_selector core_selector_inst (
    .counts      (counts),
    .core_enable (core_enable),
    .sel_core    (sel_core),
    .sel_valid   (sel_valid)
  );

  assign head_slot = heads[sel_core];

  port_dispatch port_dispatch_inst (
    .clk       (clk),
    .rst_r     (rst_r),
    .rx_beat   (rx_beat),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .sel_core  (sel_core),
    .sel_valid (sel_valid),
    .head_slot (head_slot),
    .desc_pop  (desc_pop)
  );

  // Any dropped return shows up one cycle later
  always_ff @(posedge clk) begin
    if (rst_r) begin
      slot_err <= 1'b0;
    end else begin
      slot_err <= |enq_err;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam real HALF_PERIOD = 4.0;

  initial begin
    clk = 1'b0;
  end

  // 8 ns period
  always begin
    #(HALF_PERIOD) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- tests/packet_scheduler_sva.sv
`timescale 1ns/1ps
`default_nettype none

module packet_scheduler_sva (
  input wire                                                   clk,
  input wire                                                   rst_r,
  input wire sched_pkg::ctrl_msg_t                             ctrl_msg,
  input wire                                                   ctrl_valid,
  input wire [sched_pkg::CORE_COUNT-1:0]                       core_enable,
  input wire sched_pkg::rx_beat_t [sched_pkg::PORT_COUNT-1:0]  rx_beat,
  input wire [sched_pkg::PORT_COUNT-1:0]                       rx_valid,
  input wire [sched_pkg::PORT_COUNT-1:0]                       rx_ready,
  input wire sched_pkg::tagged_beat_t [sched_pkg::PORT_COUNT-1:0] out_beat,
  input wire [sched_pkg::PORT_COUNT-1:0]                       out_valid,
  input wire [sched_pkg::PORT_COUNT-1:0]                       out_ready,
  input wire                                                   slot_err,
  input wire [sched_pkg::CORE_COUNT-1:0]                       keeper_pop
);

  import sched_pkg::*;

  int unsigned           fail_count = 0;
  logic                  slots_seen;
  logic [CORE_COUNT-1:0] pend_init;
  logic [CORE_COUNT-1:0] pend_ret;
  slot_t                 pend_val;
  slot_t                 occ [CORE_COUNT];
  slot_t                 init_n [CORE_COUNT];
  int unsigned           credits [CORE_COUNT];
  int unsigned           starts [CORE_COUNT];
  logic                  err_exp;
  logic [PORT_COUNT-1:0] in_pkt;
  dest_tag_t             pkt_dest [PORT_COUNT];
  logic [PORT_COUNT-1:0] xfer;

  assign xfer = rx_valid & rx_ready;

  // Messages reach the lists one edge after they are sampled
  always_ff @(posedge clk) begin
    pend_val <= ctrl_msg.slot;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (rst_r) begin
        pend_init[c] <= 1'b0;
        pend_ret[c]  <= 1'b0;
      end else begin
        pend_init[c] <= ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_INIT) &&
                        (ctrl_msg.src_core == core_id_t'(c));
        pend_ret[c]  <= ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_RETURN) &&
                        (ctrl_msg.src_core == core_id_t'(c));
      end
    end
  end

  // Reference model of list occupancy, credits and packet starts
  always_ff @(posedge clk) begin
    slot_t       capped;
    logic        accept;
    logic        err_any;
    int unsigned add [CORE_COUNT];
    capped  = (pend_val > slot_t'(SLOT_COUNT)) ? slot_t'(SLOT_COUNT) : pend_val;
    err_any = 1'b0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      add[c] = 0;
    end
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (xfer[p] && !in_pkt[p]) begin
        add[out_beat[p].dest.core] = add[out_beat[p].dest.core] + 1;
      end
    end
    if (rst_r) begin
      slots_seen <= 1'b0;
      err_exp    <= 1'b0;
      for (int c = 0; c < CORE_COUNT; c++) begin
        occ[c]     <= '0;
        init_n[c]  <= '0;
        credits[c] <= 0;
        starts[c]  <= 0;
      end
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (pend_init[c]) begin
          occ[c]     <= capped;
          init_n[c]  <= capped;
          credits[c] <= capped;
          if (capped != '0) begin
            slots_seen <= 1'b1;
          end
        end else begin
          accept  = pend_ret[c] && !((occ[c] == slot_t'(SLOT_COUNT)) && !keeper_pop[c]);
          err_any = err_any || (pend_ret[c] && !accept);
          occ[c]  <= occ[c] + slot_t'(accept) - slot_t'(keeper_pop[c]);
          if (accept) begin
            credits[c] <= credits[c] + 1;
          end
        end
        starts[c] <= starts[c] + add[c];
      end
      err_exp <= err_any;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (rst_r) begin
        in_pkt[p] <= 1'b0;
      end else if (xfer[p]) begin
        in_pkt[p]   <= !rx_beat[p].last;
        pkt_dest[p] <= out_beat[p].dest;
      end
    end
  end

  a_idle: assert property (@(posedge clk) disable iff (rst_r)
    !slots_seen |-> (out_valid == '0) && (rx_ready == '0))
    else begin
      $error("Port active before any core had slots");
      fail_count++;
    end

  a_slot_err: assert property (@(posedge clk) disable iff (rst_r) slot_err == err_exp)
    else begin
      $error("ERR %0t slot_err got %b exp %b", $time, slot_err, err_exp);
      fail_count++;
    end

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port_chk
    a_pass: assert property (@(posedge clk) disable iff (rst_r)
      out_valid[p] |-> out_beat[p].beat == rx_beat[p])
      else begin
        $error("ERR %0t out_beat.beat got %h exp %h", $time, out_beat[p].beat, rx_beat[p]);
        fail_count++;
      end

    a_port: assert property (@(posedge clk) disable iff (rst_r)
      out_valid[p] |-> out_beat[p].port == port_id_t'(p))
      else begin
        $error("ERR %0t out_beat.port got %0d exp %0d", $time, out_beat[p].port, p);
        fail_count++;
      end

    // Output transfer must be the same event as the input transfer
    a_handshake: assert property (@(posedge clk) disable iff (rst_r)
      out_valid[p] |-> rx_valid[p] && (rx_ready[p] == out_ready[p]))
      else begin
        $error("Port %0d output handshake does not follow the input handshake", p);
        fail_count++;
      end

    a_backpressure: assert property (@(posedge clk) disable iff (rst_r)
      !out_ready[p] |-> !rx_ready[p])
      else begin
        $error("rx_ready high while out_ready low on port %0d", p);
        fail_count++;
      end

    a_dest_ok: assert property (@(posedge clk) disable iff (rst_r)
      out_valid[p] |-> core_enable[out_beat[p].dest.core] && (out_beat[p].dest.slot != '0) &&
                       (out_beat[p].dest.slot <= init_n[out_beat[p].dest.core]))
      else begin
        $error("Beat on port %0d tagged with a bad core or slot", p);
        fail_count++;
      end

    a_same_dest: assert property (@(posedge clk) disable iff (rst_r)
      xfer[p] && in_pkt[p] |-> out_beat[p].dest == pkt_dest[p])
      else begin
        $error("ERR %0t out_beat.dest got %h exp %h", $time, out_beat[p].dest, pkt_dest[p]);
        fail_count++;
      end
  end

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core_chk
    a_starts: assert property (@(posedge clk) disable iff (rst_r) starts[c] <= credits[c])
      else begin
        $error("Core %0d started more packets than it had slots", c);
        fail_count++;
      end
  end

endmodule

bind packet_scheduler packet_scheduler_sva sva_inst (
  .clk         (clk),
  .rst_r       (rst_r),
  .ctrl_msg    (ctrl_msg),
  .ctrl_valid  (ctrl_valid),
  .core_enable (core_enable),
  .rx_beat     (rx_beat),
  .rx_valid    (rx_valid),
  .rx_ready    (rx_ready),
  .out_beat    (out_beat),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .slot_err    (slot_err),
  .keeper_pop  (keeper_pop)
);

`default_nettype wire

//--- tests/packet_scheduler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module packet_scheduler_tb;

  import sched_pkg::*;

  localparam int PKTS_PER_PORT = 12;
  localparam int MAX_LEN       = 6;
  localparam int IDLE_CYCLES   = 20;
  // Ports share few slots, so packets mostly run one after another
  localparam int CYCLE_LIMIT   = 10 + IDLE_CYCLES + 2 * PKTS_PER_PORT * MAX_LEN * 4 + 100;

  logic                                clk;
  logic                                rst_r;
  ctrl_msg_t                           ctrl_msg;
  logic                                ctrl_valid;
  logic [CORE_COUNT-1:0]               core_enable;
  rx_beat_t [PORT_COUNT-1:0]           rx_beat;
  logic [PORT_COUNT-1:0]               rx_valid;
  logic [PORT_COUNT-1:0]               rx_ready;
  tagged_beat_t [PORT_COUNT-1:0]       out_beat;
  logic [PORT_COUNT-1:0]               out_valid;
  logic [PORT_COUNT-1:0]               out_ready;
  logic                                slot_err;

  logic [31:0]           lfsr_state;
  logic [PORT_COUNT-1:0] accepted;
  logic [PORT_COUNT-1:0] done_v;
  dest_tag_t             done_dest [PORT_COUNT];
  dest_tag_t             ret_q [$];
  logic                  returns_on;
  int unsigned           cycles;
  int unsigned           tests_run;
  int unsigned           tests_passed;
  int unsigned           prev_fails;

  tb_clock tb_clock_inst (.clk(clk));

  packet_scheduler packet_scheduler_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .ctrl_msg    (ctrl_msg),
    .ctrl_valid  (ctrl_valid),
    .core_enable (core_enable),
    .rx_beat     (rx_beat),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .slot_err    (slot_err)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic send_ctrl(input msg_type_t t, input int core, input int slot);
    ctrl_msg   = '{msg_type: t, src_core: core_id_t'(core), slot: slot_t'(slot)};
    ctrl_valid = 1'b1;
    @(negedge clk);
    ctrl_valid = 1'b0;
  endtask

  task automatic run_port(input int p);
    int len;
    for (int i = 0; i < PKTS_PER_PORT; i++) begin
      len = 1 + int'(take_bits(3)) % MAX_LEN;
      for (int b = 0; b < len; b++) begin
        rx_beat[p]  = '{data: {take_bits(32), take_bits(32)}, last: (b == len - 1)};
        rx_valid[p] = 1'b1;
        do begin
          @(negedge clk);
        end while (!accepted[p]);
      end
    end
    rx_valid[p] = 1'b0;
  endtask

  task automatic report(input string name);
    int unsigned fails;
    fails = packet_scheduler_inst.sva_inst.fail_count - prev_fails;
    prev_fails = packet_scheduler_inst.sva_inst.fail_count;
    tests_run++;
    if (fails == 0) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail, %0d assertion failures", name, fails);
    end
  endtask

  // Handshakes captured on the edge, used on the next falling edge
  always @(posedge clk) begin
    accepted <= rx_valid & rx_ready;
    for (int p = 0; p < PORT_COUNT; p++) begin
      done_v[p]    <= !rst_r && out_valid[p] && out_ready[p] && out_beat[p].beat.last;
      done_dest[p] <= out_beat[p].dest;
    end
  end

  // Finished packets hand their slot back to the core
  always @(negedge clk) begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (done_v[p]) begin
        ret_q.push_back(done_dest[p]);
      end
      out_ready[p] = (take_bits(2) != 0);
    end
    if (returns_on) begin
      if (ret_q.size() > 0) begin
        ctrl_msg   = '{msg_type: MSG_SLOT_RETURN, src_core: ret_q[0].core, slot: ret_q[0].slot};
        ctrl_valid = 1'b1;
        void'(ret_q.pop_front());
      end else begin
        ctrl_valid = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, packets never finished", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    lfsr_state   = 32'h4b4a;
    rst_r        = 1'b1;
    ctrl_msg     = '0;
    ctrl_valid   = 1'b0;
    core_enable  = 4'b1011;
    rx_beat      = '0;
    rx_valid     = '0;
    out_ready    = '1;
    returns_on   = 1'b0;
    cycles       = 0;
    tests_run    = 0;
    tests_passed = 0;
    prev_fails   = 0;
    repeat (10) @(negedge clk);
    rst_r = 1'b0;

    // Traffic offered while no core has slots
    rx_valid = '1;
    repeat (IDLE_CYCLES) @(negedge clk);
    rx_valid = '0;
    report("idle_without_slots");

    // Core 2 is disabled and keeps a full list for the overflow test
    // Four slots for two ports, so ports run dry and wait for returns
    send_ctrl(MSG_SLOT_INIT, 0, 2);
    send_ctrl(MSG_SLOT_INIT, 1, 1);
    send_ctrl(MSG_SLOT_INIT, 2, 4);
    send_ctrl(MSG_SLOT_INIT, 3, 1);
    returns_on = 1'b1;
    fork
      run_port(0);
      run_port(1);
    join
    while (ret_q.size() > 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    report("random_traffic");

    returns_on = 1'b0;
    ctrl_valid = 1'b0;
    send_ctrl(MSG_SLOT_RETURN, 2, 1);
    send_ctrl(MSG_SLOT_INIT, 2, 2);
    send_ctrl(MSG_SLOT_RETURN, 2, 3);
    send_ctrl(MSG_SLOT_RETURN, 2, 4);
    send_ctrl(MSG_SLOT_RETURN, 2, 1);
    repeat (4) @(negedge clk);
    report("slot_overflow");

    $display("tests run %0d, passed %0d, assertion failures %0d",
             tests_run, tests_passed, packet_scheduler_inst.sva_inst.fail_count);
    if (tests_passed == tests_run) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- packet_scheduler.f
source/sched_pkg.sv
source/ctrl_slot_decoder.sv
source/slot_keeper.sv
source/core_selector.sv
source/port_dispatch.sv
source/packet_scheduler.sv
tests/tb_clock.sv
tests/packet_scheduler_sva.sv
tests/packet_scheduler_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the packet scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module packet_scheduler_tb \
  -f packet_scheduler.f \
  --Mdir obj_dir -o sim

out=$(./obj_dir/sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi
